// ==== panel_geom_pkg.sv ====
`default_nettype none

package panel_geom_pkg;

    localparam int panel_height = 32;
    localparam int panel_width = 64;

    // address fields
    localparam int row_bits = $clog2(panel_height);
    localparam int col_bits = $clog2(panel_width);

    // row, column, then one byte-select bit (two bytes per pixel)
    localparam int ram_addr_bits = row_bits + col_bits + 1;
    localparam int ram_data_bits = 8;

    typedef logic [ram_addr_bits-1:0] ram_addr_t;

    // one write on the frame RAM port
    typedef struct packed {
        ram_addr_t addr;
        logic [ram_data_bits-1:0] data;
        logic strobe;
    } ram_write_t;

    // arguments of the write-pixel command, in arrival order
    typedef struct packed {
        logic [7:0] row;
        logic [7:0] col;
        logic [15:0] colour;
    } pixel_cmd_t;

endpackage

`default_nettype wire

// ==== panel_cmd_pkg.sv ====
`default_nettype none

package panel_cmd_pkg;

    // colour channel switches
    localparam logic [7:0] cmd_red_on = "R";
    localparam logic [7:0] cmd_red_off = "r";
    localparam logic [7:0] cmd_green_on = "G";
    localparam logic [7:0] cmd_green_off = "g";
    localparam logic [7:0] cmd_blue_on = "B";
    localparam logic [7:0] cmd_blue_off = "b";

    // plane toggles run upward from this code
    localparam logic [7:0] cmd_plane_base = "1";
    localparam logic [7:0] cmd_planes_off = "0";
    localparam logic [7:0] cmd_planes_on = "9";

    // commands with arguments or RAM work
    localparam logic [7:0] cmd_set_brightness = "T";
    localparam logic [7:0] cmd_write_pixel = "P";
    localparam logic [7:0] cmd_blank = "Z";

    // argument of the set-brightness command
    typedef struct packed {
        logic [7:0] level;
    } brightness_cmd_t;

    typedef enum logic [1:0] {
        idle,
        collect_brightness,
        collect_pixel,
        writing
    } dec_state_t;

endpackage

`default_nettype wire

// ==== arg_collector.sv ====
`timescale 1ns/10ps
`default_nettype none

module arg_collector #(
    parameter type payload_t = logic [7:0]
) (
    input wire logic clk_in,
    input wire logic reset,
    input wire logic [7:0] rx_data,
    input wire logic take,
    output logic done,
    output payload_t payload
);

    localparam int payload_bits = $bits(payload_t);
    localparam int payload_bytes = payload_bits / 8;
    localparam int count_bits = (payload_bytes > 1) ? $clog2(payload_bytes) : 1;

    typedef logic [payload_bits-1:0] raw_t;

    logic [count_bits-1:0] byte_count;
    logic last_byte;
    raw_t shift_next;

    assign last_byte = (byte_count == count_bits'(payload_bytes - 1));

    // older bytes move up, the new one enters at the bottom
    assign shift_next = (raw_t'(payload) << 8) | raw_t'(rx_data);

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            byte_count <= '0;
            done <= 1'b0;
        end else begin
            done <= take && last_byte;
            if (take) begin
                if (last_byte) begin
                    byte_count <= '0;
                end else begin
                    byte_count <= byte_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (take) begin
            payload <= payload_t'(shift_next);
        end
    end

endmodule

`default_nettype wire

// ==== frame_writer.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_writer (
    input wire logic clk_in,
    input wire logic reset,
    input wire logic pixel_start,
    input wire panel_geom_pkg::pixel_cmd_t pixel,
    input wire logic blank_start,
    output panel_geom_pkg::ram_write_t ram_write,
    output logic write_done
);

    logic blanking;
    logic low_pending;
    panel_geom_pkg::ram_addr_t low_addr;
    logic [panel_geom_pkg::ram_data_bits-1:0] low_data;
    panel_geom_pkg::ram_addr_t next_addr;

    // row on top, column and byte-select inverted
    function automatic panel_geom_pkg::ram_addr_t pixel_addr(
        input panel_geom_pkg::pixel_cmd_t p,
        input logic byte_sel
    );
        return {p.row[panel_geom_pkg::row_bits-1:0],
                ~p.col[panel_geom_pkg::col_bits-1:0],
                ~byte_sel};
    endfunction

    assign next_addr = ram_write.addr + 1'b1;

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            ram_write <= '0;
            blanking <= 1'b0;
            low_pending <= 1'b0;
            write_done <= 1'b0;
        end else begin
            write_done <= 1'b0;
            ram_write.strobe <= 1'b0;
            if (blank_start) begin
                blanking <= 1'b1;
                ram_write.addr <= '0;
                ram_write.data <= '0;
                ram_write.strobe <= 1'b1;
            end else if (blanking) begin
                ram_write.addr <= next_addr;
                ram_write.data <= '0;
                ram_write.strobe <= 1'b1;
                // top address goes out now, sweep finished
                if (&next_addr) begin
                    blanking <= 1'b0;
                    write_done <= 1'b1;
                end
            end else if (pixel_start) begin
                // high colour byte first, at byte-select 0
                low_pending <= 1'b1;
                ram_write.addr <= pixel_addr(pixel, 1'b0);
                ram_write.data <= pixel.colour[15:8];
                ram_write.strobe <= 1'b1;
            end else if (low_pending) begin
                low_pending <= 1'b0;
                ram_write.addr <= low_addr;
                ram_write.data <= low_data;
                ram_write.strobe <= 1'b1;
                write_done <= 1'b1;
            end
        end
    end

    // second byte of the pixel, held for the next cycle
    always_ff @(posedge clk_in) begin
        if (pixel_start) begin
            low_addr <= pixel_addr(pixel, 1'b1);
            low_data <= pixel.colour[7:0];
        end
    end

endmodule

`default_nettype wire

// ==== cmd_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module cmd_decoder #(
    parameter int brightness_levels = 6
) (
    input wire logic clk_in,
    input wire logic reset,
    input wire logic [7:0] rx_data,
    input wire logic rx_valid,
    input wire logic brightness_done,
    input wire panel_cmd_pkg::brightness_cmd_t brightness_payload,
    input wire logic pixel_done,
    input wire logic write_done,
    output logic rx_ready,
    output logic [2:0] rgb_enable,
    output logic [brightness_levels-1:0] brightness_enable,
    output logic busy,
    output logic brightness_take,
    output logic pixel_take,
    output logic pixel_start,
    output logic blank_start
);

    panel_cmd_pkg::dec_state_t state;
    logic accept;
    logic in_idle;
    logic [brightness_levels-1:0] plane_toggle;

    assign in_idle = (state == panel_cmd_pkg::idle);

    // hold off while frame_writer runs and during a collector's done cycle
    assign rx_ready = (state != panel_cmd_pkg::writing) && !brightness_done && !pixel_done;
    assign accept = rx_valid && rx_ready;
    assign busy = !in_idle;

    assign brightness_take = accept && (state == panel_cmd_pkg::collect_brightness);
    assign pixel_take = accept && (state == panel_cmd_pkg::collect_pixel);

    assign blank_start = accept && in_idle && (rx_data == panel_cmd_pkg::cmd_blank);
    assign pixel_start = pixel_done && (state == panel_cmd_pkg::collect_pixel);

    // "1" hits the top plane, each following digit the next one down
    always_comb begin
        plane_toggle = '0;
        for (int k = 0; k < brightness_levels; k++) begin
            if (rx_data == panel_cmd_pkg::cmd_plane_base + 8'(k)) begin
                plane_toggle[brightness_levels-1-k] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state <= panel_cmd_pkg::idle;
            rgb_enable <= 3'b111;
            brightness_enable <= '1;
        end else begin
            case (state)
                panel_cmd_pkg::idle: begin
                    if (accept) begin
                        case (rx_data)
                            panel_cmd_pkg::cmd_red_on: begin
                                rgb_enable[0] <= 1'b1;
                            end
                            panel_cmd_pkg::cmd_red_off: begin
                                rgb_enable[0] <= 1'b0;
                            end
                            panel_cmd_pkg::cmd_green_on: begin
                                rgb_enable[1] <= 1'b1;
                            end
                            panel_cmd_pkg::cmd_green_off: begin
                                rgb_enable[1] <= 1'b0;
                            end
                            panel_cmd_pkg::cmd_blue_on: begin
                                rgb_enable[2] <= 1'b1;
                            end
                            panel_cmd_pkg::cmd_blue_off: begin
                                rgb_enable[2] <= 1'b0;
                            end
                            panel_cmd_pkg::cmd_planes_off: begin
                                brightness_enable <= '0;
                            end
                            panel_cmd_pkg::cmd_planes_on: begin
                                brightness_enable <= '1;
                            end
                            panel_cmd_pkg::cmd_set_brightness: begin
                                state <= panel_cmd_pkg::collect_brightness;
                            end
                            panel_cmd_pkg::cmd_write_pixel: begin
                                state <= panel_cmd_pkg::collect_pixel;
                            end
                            panel_cmd_pkg::cmd_blank: begin
                                state <= panel_cmd_pkg::writing;
                            end
                            default: begin
                                // zero mask for anything that is not a plane digit
                                brightness_enable <= brightness_enable ^ plane_toggle;
                            end
                        endcase
                    end
                end
                panel_cmd_pkg::collect_brightness: begin
                    if (brightness_done) begin
                        brightness_enable <= brightness_payload.level[brightness_levels-1:0];
                        state <= panel_cmd_pkg::idle;
                    end
                end
                panel_cmd_pkg::collect_pixel: begin
                    if (pixel_done) begin
                        state <= panel_cmd_pkg::writing;
                    end
                end
                panel_cmd_pkg::writing: begin
                    if (write_done) begin
                        state <= panel_cmd_pkg::idle;
                    end
                end
                default: begin
                    state <= panel_cmd_pkg::idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== panel_ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module panel_ctrl_top #(
    parameter int brightness_levels = 6
) (
    input wire logic clk_in,
    input wire logic reset,
    input wire logic [7:0] rx_data,
    input wire logic rx_valid,
    output logic rx_ready,
    output logic [2:0] rgb_enable,
    output logic [brightness_levels-1:0] brightness_enable,
    output panel_geom_pkg::ram_write_t ram_write,
    output logic busy
);

    logic brightness_take;
    logic brightness_done;
    panel_cmd_pkg::brightness_cmd_t brightness_payload;

    logic pixel_take;
    logic pixel_done;
    panel_geom_pkg::pixel_cmd_t pixel_payload;

    logic pixel_start;
    logic blank_start;
    logic write_done;

    cmd_decoder #(
        .brightness_levels(brightness_levels)
    ) u_cmd_decoder (
        .clk_in(clk_in),
        .reset(reset),
        .rx_data(rx_data),
        .rx_valid(rx_valid),
        .brightness_done(brightness_done),
        .brightness_payload(brightness_payload),
        .pixel_done(pixel_done),
        .write_done(write_done),
        .rx_ready(rx_ready),
        .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable),
        .busy(busy),
        .brightness_take(brightness_take),
        .pixel_take(pixel_take),
        .pixel_start(pixel_start),
        .blank_start(blank_start)
    );

    // one byte for "T"
    arg_collector #(
        .payload_t(panel_cmd_pkg::brightness_cmd_t)
    ) u_brightness_args (
        .clk_in(clk_in),
        .reset(reset),
        .rx_data(rx_data),
        .take(brightness_take),
        .done(brightness_done),
        .payload(brightness_payload)
    );

    // row, column and two colour bytes for "P"
    arg_collector #(
        .payload_t(panel_geom_pkg::pixel_cmd_t)
    ) u_pixel_args (
        .clk_in(clk_in),
        .reset(reset),
        .rx_data(rx_data),
        .take(pixel_take),
        .done(pixel_done),
        .payload(pixel_payload)
    );

    frame_writer u_frame_writer (
        .clk_in(clk_in),
        .reset(reset),
        .pixel_start(pixel_start),
        .pixel(pixel_payload),
        .blank_start(blank_start),
        .ram_write(ram_write),
        .write_done(write_done)
    );

endmodule

`default_nettype wire

// ==== tb_panel_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_panel_ctrl;

    localparam int brightness_levels = 6;
    localparam int ram_bytes = 4096;
    localparam int n_basic = 40;
    localparam int n_bright = 8;
    localparam int n_pixel = 10;
    localparam int n_undef = 6;
    localparam int n_commands = n_basic + n_bright + n_pixel + n_undef + 2;
    localparam int watchdog_cycles = n_commands * 5000;

    // colour and plane codes with the first character in the top byte
    localparam logic [8*14-1:0] basic_codes = "RrGgBb12345609";
    localparam logic [8*6-1:0] undefined_codes = {"78xp", 8'h00, 8'hff};

    typedef struct packed {
        logic [2:0] rgb;
        logic [brightness_levels-1:0] planes;
    } panel_state_t;

    logic clk_in;
    logic reset;
    logic [7:0] rx_data;
    logic rx_valid;
    logic rx_ready;
    logic [2:0] rgb_enable;
    logic [brightness_levels-1:0] brightness_enable;
    panel_geom_pkg::ram_write_t ram_write;
    logic busy;

    panel_state_t model;
    logic [7:0] model_ram [0:ram_bytes-1];
    logic [7:0] shadow_ram [0:ram_bytes-1];
    int touched [$];
    int expected_writes = 0;
    int write_count = 0;
    int errors = 0;
    integer seed;
    logic [31:0] rnd;
    logic check_req = 1'b0;

    panel_ctrl_top #(
        .brightness_levels(brightness_levels)
    ) u_panel_ctrl_top (
        .clk_in(clk_in),
        .reset(reset),
        .rx_data(rx_data),
        .rx_valid(rx_valid),
        .rx_ready(rx_ready),
        .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable),
        .ram_write(ram_write),
        .busy(busy)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // startup contents so that a blank is visible
    function automatic logic [7:0] fill_byte(input int a);
        logic [11:0] addr;
        addr = a[11:0];
        return addr[7:0] ^ addr[11:4] ^ 8'h5a;
    endfunction

    function automatic void apply_command(input logic [7:0] cmd, input logic [31:0] args);
        int a;
        int k;
        logic [brightness_levels-1:0] mask;
        mask = '0;
        case (cmd)
            "R": model.rgb = model.rgb | 3'b001;
            "r": model.rgb = model.rgb & 3'b110;
            "G": model.rgb = model.rgb | 3'b010;
            "g": model.rgb = model.rgb & 3'b101;
            "B": model.rgb = model.rgb | 3'b100;
            "b": model.rgb = model.rgb & 3'b011;
            "0": model.planes = '0;
            "9": model.planes = '1;
            "T": model.planes = args[brightness_levels-1:0];
            "P": begin
                // row * 128 plus inverted column * 2 plus one for the high byte
                a = args[28:24] * 128 + (63 - args[21:16]) * 2 + 1;
                model_ram[a] = args[15:8];
                model_ram[a - 1] = args[7:0];
                touched.push_back(a);
                touched.push_back(a - 1);
                expected_writes += 2;
            end
            "Z": begin
                for (a = 0; a < ram_bytes; a++) begin
                    model_ram[a] = 8'h00;
                    touched.push_back(a);
                end
                expected_writes += ram_bytes;
            end
            default: begin
                if (cmd >= "1" && cmd < "1" + brightness_levels) begin
                    k = cmd - "1";
                    mask[brightness_levels - 1 - k] = 1'b1;
                    model.planes = model.planes ^ mask;
                end
            end
        endcase
    endfunction

    // how long busy stays up after the last byte of a command
    function automatic int busy_cycles(input logic [7:0] cmd);
        case (cmd)
            "T": return 1;
            "P": return 3;
            default: return 0;
        endcase
    endfunction

    task automatic compare_value(input logic [31:0] got, input logic [31:0] expected,
                                 input string what);
        if (got !== expected) begin
            errors++;
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
            $display("TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(posedge clk_in);
        rx_data <= b;
        rx_valid <= 1'b1;
        @(negedge clk_in);
        while (!rx_ready) begin
            @(negedge clk_in);
        end
        // transfer happens on this edge
        @(posedge clk_in);
        rx_valid <= 1'b0;
    endtask

    task automatic wait_idle(output int cycles);
        cycles = 0;
        @(negedge clk_in);
        while (busy) begin
            cycles++;
            @(negedge clk_in);
        end
    endtask

    task automatic request_compare();
        check_req = 1'b1;
        wait (!check_req);
    endtask

    task automatic run_command(input logic [7:0] cmd, input logic [31:0] args, input int nargs);
        int i;
        int cycles;
        send_byte(cmd);
        for (i = nargs - 1; i >= 0; i--) begin
            send_byte(args[i*8 +: 8]);
        end
        apply_command(cmd, args);
        wait_idle(cycles);
        compare_value(cycles, busy_cycles(cmd), "busy cycles after the last byte");
        request_compare();
    endtask

    // blank with the next byte already offered during the sweep
    task automatic blank_then_send(input logic [7:0] next_cmd);
        int cycles;
        send_byte("Z");
        apply_command("Z", 32'h0);
        @(posedge clk_in);
        rx_data <= next_cmd;
        rx_valid <= 1'b1;
        @(negedge clk_in);
        while (!rx_ready) begin
            compare_value(busy, 1'b1, "busy while rx_ready is low");
            @(negedge clk_in);
        end
        compare_value(busy, 1'b0, "busy when the held byte is taken");
        @(posedge clk_in);
        rx_valid <= 1'b0;
        apply_command(next_cmd, 32'h0);
        wait_idle(cycles);
        compare_value(cycles, busy_cycles(next_cmd), "busy cycles after the held byte");
        request_compare();
    endtask

    // shadow of the frame RAM
    always @(negedge clk_in) begin
        if (ram_write.strobe) begin
            shadow_ram[ram_write.addr] <= ram_write.data;
            write_count <= write_count + 1;
        end
    end

    initial begin : compare_outputs
        int a;
        forever begin
            wait (check_req);
            compare_value(rgb_enable, model.rgb, "rgb_enable");
            compare_value(brightness_enable, model.planes, "brightness_enable");
            compare_value(busy, 1'b0, "busy");
            compare_value(rx_ready, 1'b1, "rx_ready");
            compare_value(write_count, expected_writes, "ram write count");
            while (touched.size() > 0) begin
                a = touched.pop_front();
                compare_value(shadow_ram[a], model_ram[a], $sformatf("ram byte %0d", a));
            end
            check_req = 1'b0;
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk_in);
        $display("timeout: the command sequence did not finish in %0d cycles", watchdog_cycles);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int i;
        seed = 32'h354a787d;
        reset = 1'b1;
        rx_data = 8'h00;
        rx_valid = 1'b0;
        for (i = 0; i < ram_bytes; i++) begin
            model_ram[i] = fill_byte(i);
            shadow_ram[i] = fill_byte(i);
        end
        model.rgb = 3'b111;
        model.planes = '1;
        repeat (8) @(posedge clk_in);
        reset <= 1'b0;
        @(negedge clk_in);
        compare_value(ram_write.strobe, 1'b0, "ram strobe after reset");
        request_compare();

        for (i = 0; i < n_basic; i++) begin
            rnd = $random(seed);
            run_command(basic_codes[(13 - rnd % 14) * 8 +: 8], 32'h0, 0);
        end
        for (i = 0; i < n_bright; i++) begin
            rnd = $random(seed);
            run_command("T", {24'h0, rnd[7:0]}, 1);
        end
        // row, column, colour high, colour low
        for (i = 0; i < n_pixel; i++) begin
            rnd = $random(seed);
            run_command("P", {3'b000, rnd[4:0], 2'b00, rnd[10:5], rnd[26:11]}, 4);
        end
        for (i = 0; i < n_undef; i++) begin
            run_command(undefined_codes[(5 - i) * 8 +: 8], 32'h0, 0);
        end
        blank_then_send("g");

        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== panel_ctrl.f ====
panel_geom_pkg.sv
panel_cmd_pkg.sv
arg_collector.sv
frame_writer.sv
cmd_decoder.sv
panel_ctrl_top.sv
tb_panel_ctrl.sv
